// ==== common/lsu_pkg.sv ====
/*
 * Shared types for the load store unit: funct3 width codes,
 * exception codes, issue/request/writeback/exception structs,
 * load attribute record and the scratch address map base
 */
package lsu_pkg;

    ////////////////////
    // Address map
    localparam logic [31:0] SCRATCH_BASE = 32'h0000_0000;

    ////////////////////
    // Encodings

    // RISC-V funct3 values for loads and stores
    typedef enum logic [2:0] {
        LS_B = 3'b000,
        LS_H = 3'b001,
        LS_W = 3'b010,
        L_BU = 3'b100,
        L_HU = 3'b101
    } ls_fn3_t;

    // Matches the mcause values of the privileged spec
    typedef enum logic [4:0] {
        LOAD_ADDR_MISALIGNED  = 5'd4,
        STORE_ADDR_MISALIGNED = 5'd6
    } exc_code_t;

    typedef logic [2:0] id_t;

    ////////////////////
    // Packets
    typedef struct packed {
        logic [31:0]        rs1;
        logic signed [11:0] offset;
        logic [31:0]        rs2;
        ls_fn3_t            fn3;
        logic               load;
        logic               store;
        id_t                id;
    } ls_inputs_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        we;
    } mem_req_t;

    typedef struct packed {
        logic        done;
        id_t         id;
        logic [31:0] rd;
    } wb_packet_t;

    typedef struct packed {
        logic        valid;
        exc_code_t   code;
        logic [31:0] tval;
        id_t         id;
    } exception_packet_t;

    // What a load needs once its data comes back
    // unit is 0 for scratch RAM, 1 for the bus
    typedef struct packed {
        ls_fn3_t    fn3;
        logic [1:0] byte_addr;
        id_t        id;
        logic       unit;
    } load_attr_t;

endpackage

// ==== rtl/load_store_unit/load_attr_fifo.sv ====
/*
 * Circular FIFO of load attributes for loads in flight,
 * head entry visible on the output
 */
`timescale 1ns/1ps

module load_attr_fifo import lsu_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  load_attr_t data_in,
    input  logic       pop,
    output load_attr_t data_out,
    output logic       valid,
    output logic       full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    load_attr_t    entries [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // Wrap explicitly so non power of two depths work
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CW'(DEPTH));

endmodule

// ==== rtl/scratch_ram.sv ====
/*
 * Single-cycle data scratch RAM sub-unit with byte-enable
 * writes and a registered read
 */
`timescale 1ns/1ps

module scratch_ram import lsu_pkg::*; #(
    parameter int WORDS = 1024
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        new_request,
    input  mem_req_t    req,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] rdata
);

    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [31:0]   mem [WORDS];
    logic [31:0]   local_addr;
    logic [AW-1:0] word_idx;

    assign local_addr = req.addr - SCRATCH_BASE;
    assign word_idx   = local_addr[AW+1:2];

    // Write lands at the issue edge, read data one cycle later
    always_ff @(posedge clk) begin
        if (new_request) begin
            if (req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.be[i]) begin
                        mem[word_idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[word_idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= new_request & ~req.we;
        end
    end

    // Never back-pressures
    assign ready = 1'b1;

endmodule

// ==== rtl/bus_master.sv ====
/*
 * External bus sub-unit: one outstanding transaction,
 * request strobe out, acknowledge pulse back
 */
`timescale 1ns/1ps

module bus_master import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        new_request,
    input  mem_req_t    req,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] rdata,
    output logic        bus_req_valid,
    output mem_req_t    bus_req,
    input  logic        bus_ack,
    input  logic [31:0] bus_rdata
);

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } bus_state_t;

    bus_state_t state;
    mem_req_t   req_r;

    ////////////////////
    // Request capture
    always_ff @(posedge clk) begin
        if (new_request && state == IDLE) begin
            req_r <= req;
        end
    end

    ////////////////////
    // FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            bus_req_valid <= 1'b0;
        end else begin
            // Strobe is high only for the first cycle of WAIT_ACK
            bus_req_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (new_request) begin
                        state         <= WAIT_ACK;
                        bus_req_valid <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    if (bus_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign bus_req = req_r;
    assign ready   = (state == IDLE);

    // Read data passes straight through on the acknowledge
    assign data_valid = (state == WAIT_ACK) & bus_ack & ~req_r.we;
    assign rdata      = bus_rdata;

endmodule

// ==== rtl/load_store_unit/load_store_unit.sv ====
/*
 * Load store unit: address generation, misalignment exceptions,
 * store byte enables, scratch/bus select with unit switch stall,
 * load data alignment and extension, writeback
 */
`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*; #(
    parameter int SCRATCH_WORDS = 1024,
    parameter int ATTR_DEPTH    = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  ls_inputs_t        ls_in,
    output logic              ready,
    output logic              store_complete,
    output id_t               store_id,
    output exception_packet_t ls_exception,
    output wb_packet_t        wb,
    output logic              bus_req_valid,
    output mem_req_t          bus_req,
    input  logic              bus_ack,
    input  logic [31:0]       bus_rdata,
    output logic              idle
);

    localparam logic [31:0] SCRATCH_END = SCRATCH_BASE + 32'(SCRATCH_WORDS * 4);

    logic [31:0] eff_addr;
    logic        misaligned;
    logic [3:0]  be;
    mem_req_t    req;

    logic        accept;
    logic        issue_request;
    logic        current_unit;
    logic        last_unit;
    logic        unit_switch_stall;

    logic        scratch_ready;
    logic        scratch_dv;
    logic [31:0] scratch_rdata;
    logic        bus_ready;
    logic        bus_dv;
    logic [31:0] bus_data;

    load_attr_t  attr_in;
    load_attr_t  attr_head;
    logic        attr_valid;
    logic        attr_full;

    logic        load_complete;
    logic [31:0] muxed_data;
    logic [31:0] aligned_data;
    logic [31:0] final_data;

    ////////////////////
    // Address generation
    assign eff_addr = ls_in.rs1 + {{20{ls_in.offset[11]}}, ls_in.offset};

    always_comb begin
        case (ls_in.fn3)
            LS_H, L_HU: misaligned = eff_addr[0];
            LS_W:       misaligned = |eff_addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // Stores only; loads leave all enables clear
    always_comb begin
        be = 4'b0000;
        case (ls_in.fn3[1:0])
            2'b00: be[eff_addr[1:0]] = 1'b1;
            2'b01: be = eff_addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        if (!ls_in.store) begin
            be = 4'b0000;
        end
    end

    assign req.addr  = eff_addr;
    assign req.wdata = ls_in.rs2;
    assign req.be    = be;
    assign req.we    = ls_in.store;

    ////////////////////
    // Issue and exceptions
    assign accept        = issue_valid & ready;
    assign issue_request = accept & ~misaligned;

    assign ls_exception.valid = accept & misaligned;
    assign ls_exception.code  = ls_in.store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
    assign ls_exception.tval  = eff_addr;
    assign ls_exception.id    = ls_in.id;

    assign store_complete = issue_request & ls_in.store;
    assign store_id       = ls_in.id;

    ////////////////////
    // Unit tracking
    // Scratch decode, everything else goes out on the bus
    assign current_unit = ~((eff_addr >= SCRATCH_BASE) && (eff_addr < SCRATCH_END));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_unit <= 1'b0;
        end else if (issue_request && ls_in.load) begin
            last_unit <= current_unit;
        end
    end

    // Hold off a unit change until older loads have returned,
    // so the two units never return data in the same cycle
    assign unit_switch_stall = (current_unit != last_unit) & attr_valid;

    assign ready = bus_ready & scratch_ready & ~attr_full & ~unit_switch_stall;
    assign idle  = ~attr_valid & bus_ready;

    ////////////////////
    // Load attributes
    assign attr_in.fn3       = ls_in.fn3;
    assign attr_in.byte_addr = eff_addr[1:0];
    assign attr_in.id        = ls_in.id;
    assign attr_in.unit      = current_unit;

    assign load_complete = scratch_dv | bus_dv;

    load_attr_fifo #(
        .DEPTH(ATTR_DEPTH)
    ) attr_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (issue_request & ls_in.load),
        .data_in (attr_in),
        .pop     (load_complete),
        .data_out(attr_head),
        .valid   (attr_valid),
        .full    (attr_full)
    );

    ////////////////////
    // Sub-units
    scratch_ram #(
        .WORDS(SCRATCH_WORDS)
    ) scratch (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_request(issue_request & ~current_unit),
        .req        (req),
        .ready      (scratch_ready),
        .data_valid (scratch_dv),
        .rdata      (scratch_rdata)
    );

    bus_master bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_request  (issue_request & current_unit),
        .req          (req),
        .ready        (bus_ready),
        .data_valid   (bus_dv),
        .rdata        (bus_data),
        .bus_req_valid(bus_req_valid),
        .bus_req      (bus_req),
        .bus_ack      (bus_ack),
        .bus_rdata    (bus_rdata)
    );

    ////////////////////
    // Load data return
    assign muxed_data = attr_head.unit ? bus_data : scratch_rdata;

    // Halfword first, then the byte within it
    always_comb begin
        aligned_data[31:16] = muxed_data[31:16];
        aligned_data[15:0]  = attr_head.byte_addr[1] ? muxed_data[31:16] : muxed_data[15:0];
        if (attr_head.byte_addr[0]) begin
            aligned_data[7:0] = aligned_data[15:8];
        end
    end

    always_comb begin
        case (attr_head.fn3)
            LS_B:    final_data = {{24{aligned_data[7]}}, aligned_data[7:0]};
            LS_H:    final_data = {{16{aligned_data[15]}}, aligned_data[15:0]};
            L_BU:    final_data = {24'd0, aligned_data[7:0]};
            L_HU:    final_data = {16'd0, aligned_data[15:0]};
            default: final_data = aligned_data;
        endcase
    end

    assign wb.done = load_complete;
    assign wb.id   = attr_head.id;
    assign wb.rd   = final_data;

endmodule

// ==== rtl/lsu_top.sv ====
/*
 * Top level of the load store unit; sets the scratch size
 * and attribute FIFO depth
 */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int SCRATCH_WORDS = 1024,
    parameter int ATTR_DEPTH    = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  ls_inputs_t        ls_in,
    output logic              ready,
    output logic              store_complete,
    output id_t               store_id,
    output exception_packet_t ls_exception,
    output wb_packet_t        wb,
    output logic              bus_req_valid,
    output mem_req_t          bus_req,
    input  logic              bus_ack,
    input  logic [31:0]       bus_rdata,
    output logic              idle
);

    load_store_unit #(
        .SCRATCH_WORDS(SCRATCH_WORDS),
        .ATTR_DEPTH   (ATTR_DEPTH)
    ) lsu (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .ls_in         (ls_in),
        .ready         (ready),
        .store_complete(store_complete),
        .store_id      (store_id),
        .ls_exception  (ls_exception),
        .wb            (wb),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_ack       (bus_ack),
        .bus_rdata     (bus_rdata),
        .idle          (idle)
    );

endmodule

// ==== dv/lsu_tb.sv ====
/*
 * Testbench for lsu_top with LCG driven loads and stores, an external
 * memory responder, a reference model with expected writeback and
 * bus request queues, and a watchdog
 */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int          CLK_PERIOD    = 100;
    localparam int          DRIVE_DELAY   = 10;
    localparam int          SCRATCH_WORDS = 1024;
    localparam int          ATTR_DEPTH    = 2;
    localparam int          N_OPS         = 2000;
    localparam int          SCR_USE_WORDS = 64;
    localparam int          SCR_IDX_BITS  = 6;
    localparam logic [31:0] SCRATCH_BYTES = 32'(SCRATCH_WORDS * 4);
    localparam logic [31:0] EXT_BASE      = 32'h8000_1000;
    localparam int          EXT_BYTES     = 1024;
    localparam int          DRAIN_LIMIT   = 64;
    localparam longint      WATCHDOG_NS   = longint'(N_OPS) * 8 * CLK_PERIOD;

    typedef struct packed {
        id_t         id;
        logic [31:0] rd;
        logic        scratch;
        logic [31:0] cycle;
    } wb_expect_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        we;
        logic [31:0] cycle;
    } bus_expect_t;

    logic              clk;
    logic              rst_n;
    logic              issue_valid;
    ls_inputs_t        ls_in;
    logic              ready;
    logic              store_complete;
    id_t               store_id;
    exception_packet_t ls_exception;
    wb_packet_t        wb;
    logic              bus_req_valid;
    mem_req_t          bus_req;
    logic              bus_ack;
    logic [31:0]       bus_rdata;
    logic              idle;

    logic [31:0] rng_state  = 32'h026c_88fe;
    logic [31:0] resp_state = 32'h026c_88fe ^ 32'h5bd1_e995;
    logic [31:0] cycle      = '0;
    wb_expect_t  wb_q[$];
    bus_expect_t bus_q[$];
    logic [31:0] model_scratch [SCR_USE_WORDS];
    logic [31:0] model_ext [logic [29:0]];
    logic [31:0] ext_mem [logic [29:0]];
    int          n_loads = 0;
    int          n_stores = 0;
    int          n_exc = 0;

    lsu_top #(
        .SCRATCH_WORDS(SCRATCH_WORDS),
        .ATTR_DEPTH   (ATTR_DEPTH)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .ls_in         (ls_in),
        .ready         (ready),
        .store_complete(store_complete),
        .store_id      (store_id),
        .ls_exception  (ls_exception),
        .wb            (wb),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_ack       (bus_ack),
        .bus_rdata     (bus_rdata),
        .idle          (idle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // Helpers
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = lcg_step(rng_state);
        return (rng_state >> 8) % n;
    endfunction

    // Background contents depend on the full byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] word, input ls_fn3_t fn3,
                                               input logic [1:0] lane);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[lane*8 +: 8];
        h = word[lane[1]*16 +: 16];
        case (fn3)
            LS_B:    return {{24{b[7]}}, b};
            LS_H:    return {{16{h[15]}}, h};
            L_BU:    return {24'd0, b};
            L_HU:    return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [3:0] store_enables(input ls_fn3_t fn3, input logic [1:0] lane);
        case (fn3)
            LS_B:    return 4'b0001 << lane;
            LS_H:    return lane[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // Random offset with the base chosen so that base + offset hits ea
    function automatic ls_inputs_t make_op(input logic [31:0] ea, input ls_fn3_t fn3,
                                           input logic is_load, input logic [31:0] data,
                                           input id_t id);
        ls_inputs_t op;
        op.offset = 12'(rand_below(4096));
        op.rs1    = ea - {{20{op.offset[11]}}, op.offset};
        op.rs2    = data;
        op.fn3    = fn3;
        op.load   = is_load;
        op.store  = ~is_load;
        op.id     = id;
        return op;
    endfunction

    function automatic ls_inputs_t random_op();
        logic [31:0] ea;
        logic        is_load;
        ls_fn3_t     fn3;
        is_load = (rand_below(100) < 55);
        case (rand_below(is_load ? 5 : 3))
            0:       fn3 = LS_B;
            1:       fn3 = LS_H;
            2:       fn3 = LS_W;
            3:       fn3 = L_BU;
            default: fn3 = L_HU;
        endcase
        if (rand_below(3) == 0) begin
            ea = SCRATCH_BASE + 32'(rand_below(SCR_USE_WORDS * 4));
        end else begin
            ea = EXT_BASE + 32'(rand_below(EXT_BYTES));
        end
        if (fn3 == LS_H || fn3 == L_HU) ea[0] = 1'b0;
        if (fn3 == LS_W) ea[1:0] = 2'b00;
        // Roughly one in ten misaligned with bytes promoted to words
        if (rand_below(10) == 0) begin
            if (fn3 == LS_B || fn3 == L_BU) begin
                fn3 = LS_W;
            end
            if (fn3 == LS_W) begin
                ea[1:0] = 2'(1 + rand_below(3));
            end else begin
                ea[0] = 1'b1;
            end
        end
        return make_op(ea, fn3, is_load, rng_state ^ lcg_step(rng_state), id_t'(rand_below(8)));
    endfunction

    ////////////////////
    // Checks
    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // Writeback and bus request checks run once per cycle at the falling edge
    task automatic check_returns();
        wb_expect_t  e;
        bus_expect_t b;
        if (wb.done) begin
            if (wb_q.size() == 0) begin
                $display("Writeback at %0t with no load outstanding", $time);
                stop_with_failure();
            end else begin
                e = wb_q.pop_front();
                check_value("writeback id", 32'(wb.id), 32'(e.id));
                check_value("writeback data", wb.rd, e.rd);
                if (e.scratch) begin
                    check_value("scratch load latency", cycle, e.cycle + 1);
                end
            end
        end else if (wb_q.size() != 0 && wb_q[0].scratch && cycle > wb_q[0].cycle + 1) begin
            $display("Scratch load with id %0d never wrote back", wb_q[0].id);
            stop_with_failure();
        end
        if (bus_req_valid) begin
            if (bus_q.size() == 0) begin
                $display("Bus request at %0t with no bus access pending", $time);
                stop_with_failure();
            end else begin
                b = bus_q.pop_front();
                check_value("bus request cycle", cycle, b.cycle + 1);
                check_value("bus addr", bus_req.addr, b.addr);
                check_value("bus be", 32'(bus_req.be), 32'(b.be));
                check_value("bus we", 32'(bus_req.we), 32'(b.we));
                if (b.we) begin
                    check_value("bus wdata", bus_req.wdata, b.wdata);
                end
            end
        end
    endtask

    task automatic check_quiet_issue();
        check_value("exception without issue", 32'(ls_exception.valid), 32'd0);
        check_value("store complete without issue", 32'(store_complete), 32'd0);
    endtask

    ////////////////////
    // Reference model
    task automatic model_accept(input ls_inputs_t op);
        logic [31:0] ea;
        logic        mis;
        logic        scratch;
        logic [29:0] widx;
        logic [31:0] word;
        logic [3:0]  be;
        ea  = op.rs1 + {{20{op.offset[11]}}, op.offset};
        mis = ((op.fn3 == LS_H || op.fn3 == L_HU) && ea[0]) || (op.fn3 == LS_W && ea[1:0] != 0);
        if (mis) begin
            n_exc++;
            check_value("exception valid", 32'(ls_exception.valid), 32'd1);
            check_value("exception code", 32'(ls_exception.code), op.store ? 32'd6 : 32'd4);
            check_value("exception tval", ls_exception.tval, ea);
            check_value("exception id", 32'(ls_exception.id), 32'(op.id));
            check_value("store complete on exception", 32'(store_complete), 32'd0);
        end else begin
            check_value("exception valid", 32'(ls_exception.valid), 32'd0);
            check_value("store complete", 32'(store_complete), 32'(op.store));
            if (op.store) begin
                check_value("store id", 32'(store_id), 32'(op.id));
            end
            scratch = (ea - SCRATCH_BASE) < SCRATCH_BYTES;
            widx    = ea[31:2];
            if (scratch) begin
                word = model_scratch[ea[2 +: SCR_IDX_BITS]];
            end else begin
                word = model_ext.exists(widx) ? model_ext[widx] : fill_word({widx, 2'b00});
            end
            be = op.store ? store_enables(op.fn3, ea[1:0]) : 4'b0000;
            if (op.store) begin
                n_stores++;
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) word[i*8 +: 8] = op.rs2[i*8 +: 8];
                end
                if (scratch) model_scratch[ea[2 +: SCR_IDX_BITS]] = word;
                else model_ext[widx] = word;
            end else begin
                n_loads++;
                wb_q.push_back({op.id, load_value(word, op.fn3, ea[1:0]), scratch, cycle});
            end
            if (!scratch) begin
                bus_q.push_back({ea, op.rs2, be, op.store, cycle});
            end
        end
    endtask

    ////////////////////
    // Drivers
    task automatic drive_op(input ls_inputs_t op);
        logic accepted;
        accepted = 1'b0;
        @(posedge clk);
        #(DRIVE_DELAY);
        issue_valid = 1'b1;
        ls_in       = op;
        while (!accepted) begin
            @(negedge clk);
            check_returns();
            if (ready) begin
                model_accept(op);
                accepted = 1'b1;
            end else begin
                check_quiet_issue();
                @(posedge clk);
                #(DRIVE_DELAY);
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        issue_valid = 1'b0;
        @(negedge clk);
        check_returns();
        check_quiet_issue();
    endtask

    // External memory acknowledges 1 to 4 cycles after the request
    initial begin
        mem_req_t    req;
        int unsigned lat;
        logic [29:0] widx;
        logic [31:0] word;
        bus_ack   = 1'b0;
        bus_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && bus_req_valid) begin
                req        = bus_req;
                resp_state = lcg_step(resp_state);
                lat        = 1 + (resp_state >> 8) % 4;
                widx       = req.addr[31:2];
                word       = ext_mem.exists(widx) ? ext_mem[widx] : fill_word({widx, 2'b00});
                if (req.we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (req.be[i]) word[i*8 +: 8] = req.wdata[i*8 +: 8];
                    end
                    ext_mem[widx] = word;
                end
                repeat (lat) @(posedge clk);
                #(DRIVE_DELAY);
                bus_ack   = 1'b1;
                bus_rdata = req.we ? 32'h0 : word;
                @(posedge clk);
                #(DRIVE_DELAY);
                bus_ack   = 1'b0;
                bus_rdata = '0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the test finished", $time);
        stop_with_failure();
    end

    ////////////////////
    // Main sequence
    initial begin
        int unsigned drain_cycles;
        issue_valid = 1'b0;
        ls_in       = '0;
        rst_n       = 1'b0;
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ready after reset", 32'(ready), 32'd1);
        check_value("idle after reset", 32'(idle), 32'd1);
        check_value("wb done after reset", 32'(wb.done), 32'd0);
        check_value("bus request after reset", 32'(bus_req_valid), 32'd0);
        check_quiet_issue();

        // Fill the scratch window the random loads read from
        for (int i = 0; i < SCR_USE_WORDS; i++) begin
            drive_op(make_op(SCRATCH_BASE + 32'(i * 4), LS_W, 1'b0, fill_word(32'(i * 4)),
                             id_t'(i)));
        end
        for (int n = 0; n < N_OPS; n++) begin
            if (rand_below(8) == 0) begin
                idle_cycle();
            end
            drive_op(random_op());
        end

        drain_cycles = 0;
        while ((wb_q.size() != 0 || bus_q.size() != 0) && drain_cycles < DRAIN_LIMIT) begin
            idle_cycle();
            drain_cycles++;
        end
        if (drain_cycles >= DRAIN_LIMIT) begin
            $display("Accesses still outstanding after %0d idle cycles", DRAIN_LIMIT);
            stop_with_failure();
        end else begin
            // The last bus acknowledge trails its request by up to four cycles
            repeat (6) idle_cycle();
            check_value("idle at end", 32'(idle), 32'd1);
            $display("%0d loads, %0d stores, %0d misaligned", n_loads, n_stores, n_exc);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== project.f ====
common/lsu_pkg.sv
rtl/load_store_unit/load_attr_fifo.sv
rtl/scratch_ram.sv
rtl/bus_master.sv
rtl/load_store_unit/load_store_unit.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
